// ==== files.f ====
logic/pkt_pkg.sv
logic/stream_fifo.sv
logic/pkt_generator.sv
logic/pkt_checker.sv
logic/pkt_gen_check_array.sv
tb/tb_clock.sv
tb/pkt_checker_assertions.sv
tb/pkt_gen_check_tb.sv

// ==== tb/pkt_gen_check_tb.sv ====
/* loopback testbench, the link between tx and rx stalls and corrupts bytes here
   one request in flight per port, so the expected queue never overflows */

`timescale 1ns/100ps

module pkt_gen_check_tb;

    logic                                  clk_ifc;
    logic                                  rst;
    logic [pkt_pkg::NUM_PORTS-1:0]         send_req;
    pkt_pkg::pkt_desc_t                    send_desc [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::NUM_PORTS-1:0]         busy;
    pkt_pkg::pkt_beat_t                    tx_beat   [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::NUM_PORTS-1:0]         tx_valid;
    logic [pkt_pkg::NUM_PORTS-1:0]         tx_ready;
    pkt_pkg::pkt_beat_t                    rx_beat   [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::NUM_PORTS-1:0]         rx_valid;
    logic [pkt_pkg::NUM_PORTS-1:0]         rx_ready;
    logic [pkt_pkg::CNT_W-1:0]             pkt_count [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::CNT_W-1:0]             err_count [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::NUM_PORTS-1:0]         err_pulse;

    // link control
    logic                                  stall_en;
    logic [pkt_pkg::NUM_PORTS-1:0]         stall;
    logic [pkt_pkg::NUM_PORTS-1:0]         corrupt_en;
    int                                    corrupt_pos [pkt_pkg::NUM_PORTS-1:0];
    int                                    link_idx    [pkt_pkg::NUM_PORTS-1:0];

    // tx monitor state
    pkt_pkg::pkt_desc_t                    cur_desc [pkt_pkg::NUM_PORTS-1:0];
    pkt_pkg::pkt_beat_t                    held     [pkt_pkg::NUM_PORTS-1:0];
    logic [pkt_pkg::NUM_PORTS-1:0]         hold_chk;
    int                                    fall_chk [pkt_pkg::NUM_PORTS-1:0];

    // scoreboard and random state
    int                                    sent      [pkt_pkg::NUM_PORTS-1:0];
    int                                    corrupted [pkt_pkg::NUM_PORTS-1:0];
    int                                    err_pulses [pkt_pkg::NUM_PORTS-1:0];
    logic [31:0]                           port_rng  [pkt_pkg::NUM_PORTS-1:0];
    logic [31:0]                           stall_rng;
    int                                    assert_fails [pkt_pkg::NUM_PORTS-1:0];
    int                                    afail_total;

    tb_clock u_clock (.clk_ifc(clk_ifc));

    pkt_gen_check_array u_dut (
        .clk_ifc   (clk_ifc),
        .rst       (rst),
        .send_req  (send_req),
        .send_desc (send_desc),
        .busy      (busy),
        .tx_beat   (tx_beat),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_beat   (rx_beat),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .pkt_count (pkt_count),
        .err_count (err_count),
        .err_pulse (err_pulse)
    );

    // tallies from the bound assertion modules
    for (genvar g = 0; g < pkt_pkg::NUM_PORTS; g++) begin : g_assert_tap
        assign assert_fails[g] = u_dut.g_port[g].u_chk.u_assert.fail_count;
    end

    ////////////////////
    // helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference model: each corrupted packet is one error, the rest are good
    function automatic void expected_counts(input int n_sent, input int n_corrupt,
                                            output logic [pkt_pkg::CNT_W-1:0] good,
                                            output logic [pkt_pkg::CNT_W-1:0] bad);
        good = pkt_pkg::CNT_W'(n_sent - n_corrupt);
        bad  = pkt_pkg::CNT_W'(n_corrupt);
    endfunction

    // beat j of a packet, unused lanes left zero
    function automatic pkt_pkg::pkt_beat_t mapped_beat(input pkt_pkg::pkt_desc_t d, input int j);
        pkt_pkg::pkt_beat_t b;
        int rem;
        rem = int'(d.blen) - j * pkt_pkg::DATA_BYTES;
        b = '0;
        for (int i = 0; i < pkt_pkg::DATA_BYTES; i++) begin
            if (i < rem) begin
                b.keep[i] = 1'b1;
                b.data[i*8 +: 8] = d.data[(j*pkt_pkg::DATA_BYTES + i)*8 +: 8];
            end
        end
        b.last = (rem <= pkt_pkg::DATA_BYTES);
        return b;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "wait timed out");
    endtask

    // sampled on the falling edge, away from DUT updates
    task automatic wait_idle(input int p);
        int n;
        n = 0;
        @(negedge clk_ifc);
        while (busy[p] !== 1'b0) begin
            if (n == 2000) begin
                report_timeout($sformatf("busy[%0d] to fall", p));
            end
            n++;
            @(negedge clk_ifc);
        end
    endtask

    task automatic wait_counts(input int p);
        int n;
        n = 0;
        @(negedge clk_ifc);
        while (int'(pkt_count[p]) + int'(err_count[p]) != sent[p]) begin
            if (n == 2000) begin
                report_timeout($sformatf("port %0d packet results", p));
            end
            n++;
            @(negedge clk_ifc);
        end
    endtask

    // one rising request, then wait for the packet to leave
    task automatic send_packet(input int p, input pkt_pkg::pkt_desc_t d,
                               input logic corrupt, input int pos);
        wait_idle(p);
        @(posedge clk_ifc);
        #10;
        cur_desc[p]    = d;
        corrupt_en[p]  = corrupt;
        corrupt_pos[p] = pos;
        send_desc[p]   = d;
        send_req[p]    = 1'b1;
        // accepted on this edge
        @(posedge clk_ifc);
        #10;
        send_req[p] = 1'b0;
        check_value($sformatf("busy[%0d]", p), busy[p], 1'b1);
        sent[p]++;
        if (corrupt) begin
            corrupted[p]++;
        end
        wait_idle(p);
    endtask

    // len 0 picks a random length
    task automatic one_packet(input int p, input int len, input logic corrupt_on,
                              input logic force_corrupt);
        pkt_pkg::pkt_desc_t d;
        port_rng[p] = lcg_next(port_rng[p]);
        if (len == 0) begin
            len = int'(port_rng[p][31:16] % pkt_pkg::MTU_BYTES) + 1;
        end
        d.blen = pkt_pkg::BLEN_W'(len);
        for (int k = 0; k < pkt_pkg::MTU_BYTES; k++) begin
            port_rng[p] = lcg_next(port_rng[p]);
            d.data[k*8 +: 8] = port_rng[p][31:24];
        end
        port_rng[p] = lcg_next(port_rng[p]);
        send_packet(p, d, force_corrupt || (corrupt_on && port_rng[p][31]),
                    int'(port_rng[p][23:8]) % len);
    endtask

    task automatic random_packets(input int p, input int n, input logic corrupt_on);
        for (int i = 0; i < n; i++) begin
            // first one always corrupted when enabled
            one_packet(p, 0, corrupt_on, corrupt_on && (i == 0));
        end
    endtask

    task automatic run_ports(input int n, input logic corrupt_on);
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            automatic int q = p;
            fork
                random_packets(q, n, corrupt_on);
            join_none
        end
        wait fork;
    endtask

    task automatic check_counts();
        logic [pkt_pkg::CNT_W-1:0] good;
        logic [pkt_pkg::CNT_W-1:0] bad;
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            wait_counts(p);
        end
        // err_pulse is tallied one edge after err_count steps
        @(negedge clk_ifc);
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            expected_counts(sent[p], corrupted[p], good, bad);
            check_value($sformatf("pkt_count[%0d]", p), pkt_count[p], good);
            check_value($sformatf("err_count[%0d]", p), err_count[p], bad);
            check_value($sformatf("err_pulse[%0d] count", p), err_pulses[p], bad);
        end
    endtask

    // a rise of send_req while busy must not start a packet
    task automatic ignored_request(input int p);
        one_packet(p, 8, 1'b0, 1'b0);
        one_packet(p, 12, 1'b0, 1'b0);
        // raise on the first beat of a fresh packet, hold past its end
        wait_idle(p);
        @(posedge clk_ifc);
        #10;
        send_req[p] = 1'b1;
        @(posedge clk_ifc);
        #10;
        send_req[p] = 1'b0;
        sent[p]++;
        @(posedge clk_ifc);
        #10;
        send_req[p] = 1'b1;
        wait_idle(p);
        repeat (4) begin
            @(negedge clk_ifc);
            check_value($sformatf("busy[%0d] after ignored request", p), busy[p], 1'b0);
        end
        @(posedge clk_ifc);
        #10;
        send_req[p] = 1'b0;
    endtask

    ////////////////////
    // link: tx looped to rx, stall gates both sides

    always_comb begin
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            rx_beat[p] = tx_beat[p];
            if (corrupt_en[p] && (link_idx[p] == corrupt_pos[p] / pkt_pkg::DATA_BYTES)) begin
                rx_beat[p].data[(corrupt_pos[p] % pkt_pkg::DATA_BYTES)*8 +: 8] =
                    ~tx_beat[p].data[(corrupt_pos[p] % pkt_pkg::DATA_BYTES)*8 +: 8];
            end
            rx_valid[p] = tx_valid[p] && !stall[p];
            tx_ready[p] = rx_ready[p] && !stall[p];
        end
    end

    // stall draw per port, roughly one cycle in four
    initial begin
        forever begin
            @(posedge clk_ifc);
            #10;
            for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
                stall_rng = lcg_next(stall_rng);
                stall[p] = stall_en && (stall_rng[31:30] == 2'b00);
            end
        end
    end

    ////////////////////
    // tx monitor: byte mapping, hold under stall, busy fall timing

    always @(posedge clk_ifc) begin
        pkt_pkg::pkt_beat_t exp_b;
        pkt_pkg::pkt_beat_t got_b;
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            if (rst) begin
                link_idx[p]   <= 0;
                hold_chk[p]   <= 1'b0;
                fall_chk[p]   <= 0;
                err_pulses[p] <= 0;
            end else begin
                if (err_pulse[p]) begin
                    err_pulses[p] <= err_pulses[p] + 1;
                end
                if (hold_chk[p]) begin
                    check_value($sformatf("tx_valid[%0d] under stall", p), tx_valid[p], 1'b1);
                    check_value($sformatf("tx_beat[%0d] under stall", p), tx_beat[p], held[p]);
                end
                hold_chk[p] <= tx_valid[p] && !tx_ready[p];
                held[p]     <= tx_beat[p];
                // one edge in DONE, then idle
                if (fall_chk[p] == 1) begin
                    check_value($sformatf("busy[%0d] after last", p), busy[p], 1'b1);
                    fall_chk[p] <= 2;
                end else if (fall_chk[p] == 2) begin
                    check_value($sformatf("busy[%0d] fall", p), busy[p], 1'b0);
                    fall_chk[p] <= 0;
                end
                if (tx_valid[p] && tx_ready[p]) begin
                    // last at the wrong index also shows a wrong beat count
                    exp_b = mapped_beat(cur_desc[p], link_idx[p]);
                    got_b = tx_beat[p];
                    for (int i = 0; i < pkt_pkg::DATA_BYTES; i++) begin
                        if (!exp_b.keep[i]) begin
                            got_b.data[i*8 +: 8] = 8'h00;
                        end
                    end
                    check_value($sformatf("tx_beat[%0d] beat %0d", p, link_idx[p]), got_b, exp_b);
                    if (exp_b.last) begin
                        fall_chk[p] <= 1;
                        link_idx[p] <= 0;
                    end else begin
                        link_idx[p] <= link_idx[p] + 1;
                    end
                end
            end
        end
    end

    ////////////////////
    // main sequence

    initial begin
        rst       = 1'b1;
        send_req  = '0;
        stall_en  = 1'b0;
        stall     = '0;
        corrupt_en = '0;
        stall_rng = lcg_next(32'hdee6);
        port_rng[0] = lcg_next(stall_rng);
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            if (p > 0) begin
                port_rng[p] = lcg_next(port_rng[p-1]);
            end
            send_desc[p]   = '0;
            cur_desc[p]    = '0;
            corrupt_pos[p] = 0;
            sent[p]        = 0;
            corrupted[p]   = 0;
        end
        repeat (5) @(posedge clk_ifc);
        #10;
        rst = 1'b0;

        // idle outputs after reset
        @(negedge clk_ifc);
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            check_value($sformatf("busy[%0d]", p), busy[p], 1'b0);
            check_value($sformatf("tx_valid[%0d]", p), tx_valid[p], 1'b0);
            check_value($sformatf("err_pulse[%0d]", p), err_pulse[p], 1'b0);
            check_value($sformatf("rx_ready[%0d]", p), rx_ready[p], 1'b1);
            check_value($sformatf("pkt_count[%0d]", p), pkt_count[p], 0);
            check_value($sformatf("err_count[%0d]", p), err_count[p], 0);
        end

        // clean link
        run_ports(6, 1'b0);
        check_counts();

        // back-pressure on every port
        stall_en = 1'b1;
        run_ports(8, 1'b0);
        check_counts();

        // one flipped byte in some packets
        run_ports(8, 1'b1);
        check_counts();

        // length edges, then the ignored request on port 0
        stall_en = 1'b0;
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            automatic int q = p;
            fork
                begin
                    one_packet(q, 1, 1'b0, 1'b0);
                    one_packet(q, 4, 1'b0, 1'b0);
                    one_packet(q, 5, 1'b0, 1'b0);
                    one_packet(q, pkt_pkg::MTU_BYTES, 1'b0, 1'b0);
                end
            join_none
        end
        wait fork;
        ignored_request(0);
        check_counts();

        afail_total = 0;
        for (int p = 0; p < pkt_pkg::NUM_PORTS; p++) begin
            afail_total += assert_fails[p];
        end
        if (afail_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("%0d assertion failures in the checkers", afail_total);
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/pkt_checker_assertions.sv ====
/* protocol checks bound into every pkt_checker instance
   each failing assertion adds to fail_count, which the testbench reads at the end */

`timescale 1ns/100ps

module pkt_checker_assertions (
    input logic                        clk_ifc,
    input logic                        rst,
    input logic                        exp_push,
    input pkt_pkg::pkt_desc_t          exp_desc,
    input pkt_pkg::pkt_beat_t          rx_beat,
    input logic                        rx_valid,
    input logic [pkt_pkg::CNT_W-1:0]   pkt_count,
    input logic [pkt_pkg::CNT_W-1:0]   err_count,
    input logic                        err_pulse
);

    int fail_count = 0;

    // keep runs up from lane 0 with no holes
    a_keep_contig: assert property (@(posedge clk_ifc) disable iff (rst)
        rx_valid |-> (rx_beat.keep[0] && ((rx_beat.keep & (rx_beat.keep + 1'b1)) == '0)))
    else begin
        $error("rx keep not contiguous: %b", rx_beat.keep);
        fail_count++;
    end

    // single-cycle error strobe
    a_err_pulse_one: assert property (@(posedge clk_ifc) disable iff (rst)
        err_pulse |=> !err_pulse)
    else begin
        $error("err_pulse held for more than one cycle");
        fail_count++;
    end

    // zero-length packets are out of range
    a_blen_nonzero: assert property (@(posedge clk_ifc) disable iff (rst)
        exp_push |-> (exp_desc.blen != '0))
    else begin
        $error("expected descriptor pushed with blen zero");
        fail_count++;
    end

    ////////////////////
    // counters only step forward, modulo 2**CNT_W

    a_pkt_cnt_up: assert property (@(posedge clk_ifc) disable iff (rst)
        pkt_pkg::CNT_W'(pkt_count - $past(pkt_count)) <= 1)
    else begin
        $error("pkt_count moved backwards");
        fail_count++;
    end

    // bad packet and queue overflow may land on one edge
    a_err_cnt_up: assert property (@(posedge clk_ifc) disable iff (rst)
        pkt_pkg::CNT_W'(err_count - $past(err_count)) <= 2)
    else begin
        $error("err_count moved backwards");
        fail_count++;
    end

endmodule

bind pkt_checker pkt_checker_assertions u_assert (
    .clk_ifc   (clk_ifc),
    .rst       (rst),
    .exp_push  (exp_push),
    .exp_desc  (exp_desc),
    .rx_beat   (rx_beat),
    .rx_valid  (rx_valid),
    .pkt_count (pkt_count),
    .err_count (err_count),
    .err_pulse (err_pulse)
);

// ==== tb/tb_clock.sv ====
/* free-running testbench clock, 100 ns period, starts low */

`timescale 1ns/100ps

module tb_clock (
    output logic clk_ifc
);

    // half of the 100 ns period
    localparam time HALF_PERIOD = 50ns;

    initial begin
        clk_ifc = 1'b0;
        forever begin
            #HALF_PERIOD clk_ifc = ~clk_ifc;
        end
    end

endmodule

// ==== logic/pkt_gen_check_array.sv ====
/* NUM_PORTS generator/checker pairs, tx and rx leave the block so the link is external
   no registers at this level, timing is that of the submodules */

`timescale 1ns/100ps

module pkt_gen_check_array (
    input  logic                        clk_ifc,
    input  logic                        rst,

    // request side
    input  logic [pkt_pkg::NUM_PORTS-1:0]   send_req,
    input  pkt_pkg::pkt_desc_t              send_desc [pkt_pkg::NUM_PORTS-1:0],
    output logic [pkt_pkg::NUM_PORTS-1:0]   busy,

    // transmit streams
    output pkt_pkg::pkt_beat_t              tx_beat   [pkt_pkg::NUM_PORTS-1:0],
    output logic [pkt_pkg::NUM_PORTS-1:0]   tx_valid,
    input  logic [pkt_pkg::NUM_PORTS-1:0]   tx_ready,

    // receive streams
    input  pkt_pkg::pkt_beat_t              rx_beat   [pkt_pkg::NUM_PORTS-1:0],
    input  logic [pkt_pkg::NUM_PORTS-1:0]   rx_valid,
    output logic [pkt_pkg::NUM_PORTS-1:0]   rx_ready,

    // per-port results
    output logic [pkt_pkg::CNT_W-1:0]       pkt_count [pkt_pkg::NUM_PORTS-1:0],
    output logic [pkt_pkg::CNT_W-1:0]       err_count [pkt_pkg::NUM_PORTS-1:0],
    output logic [pkt_pkg::NUM_PORTS-1:0]   err_pulse
);

    // generator accept strobes, one per port
    logic [pkt_pkg::NUM_PORTS-1:0] accept;

    ////////////////////
    // port slices

    for (genvar p = 0; p < pkt_pkg::NUM_PORTS; p++) begin : g_port

        pkt_generator u_gen (
            .clk_ifc   (clk_ifc),
            .rst       (rst),
            .send_req  (send_req[p]),
            .send_desc (send_desc[p]),
            .busy      (busy[p]),
            .accept    (accept[p]),
            .tx_beat   (tx_beat[p]),
            .tx_valid  (tx_valid[p]),
            .tx_ready  (tx_ready[p])
        );

        // descriptor queued on the same edge the generator takes it
        pkt_checker u_chk (
            .clk_ifc   (clk_ifc),
            .rst       (rst),
            .exp_push  (accept[p]),
            .exp_desc  (send_desc[p]),
            .rx_beat   (rx_beat[p]),
            .rx_valid  (rx_valid[p]),
            .rx_ready  (rx_ready[p]),
            .pkt_count (pkt_count[p]),
            .err_count (err_count[p]),
            .err_pulse (err_pulse[p])
        );

    end

endmodule

// ==== logic/pkt_checker.sv ====
/* one port's checker, compares received beats with the oldest expected descriptor
   beats with no descriptor count as one error per packet; queue overflow counts too */

`timescale 1ns/100ps

module pkt_checker (
    input  logic                        clk_ifc,
    input  logic                        rst,

    // expected packets from the generator
    input  logic                        exp_push,
    input  pkt_pkg::pkt_desc_t          exp_desc,

    // receive stream
    input  pkt_pkg::pkt_beat_t          rx_beat,
    input  logic                        rx_valid,
    output logic                        rx_ready,

    // results
    output logic [pkt_pkg::CNT_W-1:0]   pkt_count,
    output logic [pkt_pkg::CNT_W-1:0]   err_count,
    output logic                        err_pulse
);

    // expected queue
    pkt_pkg::pkt_desc_t exp_head;
    logic               exp_full;
    logic               exp_empty;
    logic               exp_pop;

    // skid buffer
    pkt_pkg::pkt_beat_t beat;
    logic               skid_full;
    logic               skid_empty;
    logic               beat_pop;

    // packet tracking
    logic [pkt_pkg::BLEN_W-1:0]     off;
    logic [pkt_pkg::BLEN_W-1:0]     rem;
    logic                           orphan;
    logic                           no_desc;
    logic [pkt_pkg::DATA_BYTES-1:0] exp_keep;
    logic                           exp_last;
    logic                           frame_bad;
    logic                           data_bad;
    logic                           eop;

    // error causes
    pkt_pkg::err_code_t pkt_err;
    pkt_pkg::err_code_t beat_code;
    pkt_pkg::err_code_t pkt_err_next;
    pkt_pkg::err_code_t ovfl_code;

    logic pkt_good;
    logic pkt_bad;
    logic ovfl_bad;

    ////////////////////
    // queues

    stream_fifo #(
        .entry_t (pkt_pkg::pkt_desc_t),
        .depth   (pkt_pkg::EXP_DEPTH)
    ) u_exp_fifo (
        .clk_ifc   (clk_ifc),
        .rst       (rst),
        .push      (exp_push),
        .push_data (exp_desc),
        .full      (exp_full),
        .pop       (exp_pop),
        .head      (exp_head),
        .empty     (exp_empty)
    );

    stream_fifo #(
        .entry_t (pkt_pkg::pkt_beat_t),
        .depth   (pkt_pkg::SKID_DEPTH)
    ) u_skid_fifo (
        .clk_ifc   (clk_ifc),
        .rst       (rst),
        .push      (rx_valid && rx_ready),
        .push_data (rx_beat),
        .full      (skid_full),
        .pop       (beat_pop),
        .head      (beat),
        .empty     (skid_empty)
    );

    assign rx_ready = !skid_full;
    // head is consumed as soon as it shows up
    assign beat_pop = !skid_empty;
    assign eop      = beat_pop && beat.last;

    // orphan packet, or a fresh packet with nothing queued
    assign no_desc = orphan || ((off == '0) && exp_empty);

    ////////////////////
    // beat compare

    always_comb begin
        // bytes still expected at this offset, zero once past blen
        rem = (off < exp_head.blen) ? (exp_head.blen - off) : '0;
        for (int i = 0; i < pkt_pkg::DATA_BYTES; i++) begin
            exp_keep[i] = (rem > i);
        end
        exp_last  = (rem <= pkt_pkg::DATA_BYTES);
        frame_bad = (beat.keep != exp_keep) || (beat.last != exp_last);
        data_bad  = 1'b0;
        // kept lanes only
        for (int i = 0; i < pkt_pkg::DATA_BYTES; i++) begin
            if (beat.keep[i] && exp_keep[i] &&
                (beat.data[i*8 +: 8] != exp_head.data[(off+i)*8 +: 8])) begin
                data_bad = 1'b1;
            end
        end
        if (no_desc) begin
            beat_code = pkt_pkg::ERR_UNEXP;
        end else if (frame_bad) begin
            beat_code = pkt_pkg::ERR_FRAME;
        end else if (data_bad) begin
            beat_code = pkt_pkg::ERR_DATA;
        end else begin
            beat_code = pkt_pkg::ERR_NONE;
        end
    end

    // sticky, first cause wins
    assign pkt_err_next = (pkt_err != pkt_pkg::ERR_NONE) ? pkt_err : beat_code;

    assign ovfl_code = (exp_push && exp_full) ? pkt_pkg::ERR_OVFL : pkt_pkg::ERR_NONE;

    ////////////////////
    // packet end

    assign exp_pop  = eop && !no_desc;
    assign pkt_good = eop && (pkt_err_next == pkt_pkg::ERR_NONE);
    assign pkt_bad  = eop && (pkt_err_next != pkt_pkg::ERR_NONE);
    assign ovfl_bad = (ovfl_code != pkt_pkg::ERR_NONE);

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            off       <= '0;
            orphan    <= 1'b0;
            pkt_err   <= pkt_pkg::ERR_NONE;
            pkt_count <= '0;
            err_count <= '0;
            err_pulse <= 1'b0;
        end else begin
            err_pulse <= pkt_bad || ovfl_bad;
            if (pkt_good) begin
                pkt_count <= pkt_count + 1'b1;
            end
            // overflow and a bad packet can land on the same edge
            err_count <= err_count + pkt_pkg::CNT_W'(pkt_bad) + pkt_pkg::CNT_W'(ovfl_bad);
            if (eop) begin
                off     <= '0;
                orphan  <= 1'b0;
                pkt_err <= pkt_pkg::ERR_NONE;
            end else if (beat_pop) begin
                off     <= off + pkt_pkg::BLEN_W'(pkt_pkg::DATA_BYTES);
                orphan  <= no_desc;
                pkt_err <= pkt_err_next;
            end
        end
    end

endmodule

// ==== logic/pkt_generator.sv ====
/* one port's packet serializer, starts on a rising send_req while idle
   send_desc is sampled only on the accept edge; blen of 1..MTU_BYTES assumed */

`timescale 1ns/100ps

module pkt_generator (
    input  logic                clk_ifc,
    input  logic                rst,

    // request side
    input  logic                send_req,
    input  pkt_pkg::pkt_desc_t  send_desc,
    output logic                busy,
    output logic                accept,

    // transmit stream
    output pkt_pkg::pkt_beat_t  tx_beat,
    output logic                tx_valid,
    input  logic                tx_ready
);

    // idle, sending beats, one trailing busy cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_DONE
    } gen_state_t;

    gen_state_t state;

    // request edge detect
    logic req_d;

    // latched packet
    pkt_pkg::pkt_desc_t desc;

    // byte position of the current beat
    logic [pkt_pkg::BLEN_W-1:0] offset;
    logic [pkt_pkg::BLEN_W-1:0] remaining;

    logic tx_fire;

    ////////////////////
    // handshakes

    // rising edge only, a level held through busy is not a new request
    assign accept   = send_req && !req_d && (state == ST_IDLE);
    assign busy     = (state != ST_IDLE);
    assign tx_valid = (state == ST_SEND);
    assign tx_fire  = tx_valid && tx_ready;

    assign remaining = desc.blen - offset;

    ////////////////////
    // beat former

    always_comb begin
        tx_beat.data = desc.data[offset*8 +: pkt_pkg::DATA_BYTES*8];
        for (int i = 0; i < pkt_pkg::DATA_BYTES; i++) begin
            // keep lanes below the remaining length
            tx_beat.keep[i] = (remaining > i);
            // unused lanes forced to zero
            if (!tx_beat.keep[i]) begin
                tx_beat.data[i*8 +: 8] = 8'h00;
            end
        end
        tx_beat.last = (remaining <= pkt_pkg::DATA_BYTES);
    end

    ////////////////////
    // descriptor latch

    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            desc <= send_desc;
        end
    end

    ////////////////////
    // sequencer

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            state  <= ST_IDLE;
            req_d  <= 1'b0;
            offset <= '0;
        end else begin
            req_d <= send_req;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state  <= ST_SEND;
                        offset <= '0;
                    end
                end
                ST_SEND: begin
                    // holds beat and offset while stalled
                    if (tx_fire) begin
                        if (tx_beat.last) begin
                            state <= ST_DONE;
                        end else begin
                            offset <= offset + pkt_pkg::BLEN_W'(pkt_pkg::DATA_BYTES);
                        end
                    end
                end
                // busy drops one edge after the last beat
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/stream_fifo.sv ====
/* first-word-fall-through FIFO, head is valid whenever empty is low
   push while full and pop while empty are ignored */

`timescale 1ns/100ps

module stream_fifo #(
    parameter type entry_t = pkt_pkg::pkt_beat_t,
    parameter int  depth   = pkt_pkg::SKID_DEPTH
) (
    input  logic   clk_ifc,
    input  logic   rst,

    input  logic   push,
    input  entry_t push_data,
    output logic   full,

    input  logic   pop,
    output entry_t head,
    output logic   empty
);

    // storage
    entry_t mem [depth];

    // pointers and occupancy
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    // qualified strobes
    logic do_push;
    logic do_pop;

    assign full  = (int'(count) == depth);
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // fall-through read
    assign head = mem[rd_ptr];

    ////////////////////
    // data path

    always_ff @(posedge clk_ifc) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////
    // control

    always_ff @(posedge clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap by compare so depth need not be a power of two
            if (do_push) begin
                if (int'(wr_ptr) == depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (int'(rd_ptr) == depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // occupancy
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/pkt_pkg.sv ====
/* shared sizes, stream beat and packet descriptor types for the generator/checker array
   packet lengths of 1 to MTU_BYTES only, a zero blen is not a valid packet */

package pkt_pkg;

    ////////////////////
    // sizes

    // generator/checker pairs
    localparam int NUM_PORTS = 4;
    // bytes per stream beat
    localparam int DATA_BYTES = 4;
    // largest packet
    localparam int MTU_BYTES = 32;
    // holds 0..MTU_BYTES
    localparam int BLEN_W = $clog2(MTU_BYTES + 1);
    // counters wrap
    localparam int CNT_W = 16;

    // checker queue depths
    localparam int EXP_DEPTH = 4;
    localparam int SKID_DEPTH = 4;

    ////////////////////
    // stream beat

    // lane i is data[8i+7:8i], keep contiguous from lane 0
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } pkt_beat_t;

    ////////////////////
    // packet descriptor

    // packet byte k is data[8k+7:8k]
    typedef struct packed {
        logic [BLEN_W-1:0]      blen;
        logic [MTU_BYTES*8-1:0] data;
    } pkt_desc_t;

    ////////////////////
    // checker error causes

    // first cause seen in a packet is the one kept
    typedef enum logic [2:0] {
        ERR_NONE  = 3'd0,
        ERR_DATA  = 3'd1,
        ERR_FRAME = 3'd2,
        ERR_UNEXP = 3'd3,
        ERR_OVFL  = 3'd4
    } err_code_t;

endpackage
